/* rtl/fleet_macros.svh */
`ifndef FLEET_MACROS_SVH
`define FLEET_MACROS_SVH

// Square board, cells 0 .. BOARD_SIZE-1 on each axis
`define BOARD_SIZE 10

// One coordinate, wide enough for BOARD_SIZE-1
`define COORD_W 4

// Largest piece is the carrier
`define MAX_CELLS 5

// Records stored per player
`define FLEET_SLOTS 11

// Slot index and fill count width, must hold FLEET_SLOTS itself
`define SLOT_W 4

`endif

/* rtl/fleetPkg.sv */
`default_nettype none

`include "fleet_macros.svh"

package fleetPkg;

	// Ship kinds, smallest first
	typedef enum logic [2:0]
	{
		submarine,
		cruiser,
		seaplane,
		battleship,
		carrier
	} shipKind;

	typedef enum logic [1:0]
	{
		resAccepted,
		resOutOfBounds,
		resOverlap,
		resFleetFull
	} placeResult;

	typedef enum logic [2:0]
	{
		stIdle,
		stShape,
		stScan,
		stSave,
		stAck
	} ctrlState;

	// One board square
	typedef struct packed
	{
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} gridCell;

	// Cells at index count and above are zero
	typedef struct packed
	{
		shipKind                   kind;
		logic [2:0]                count;
		gridCell [`MAX_CELLS-1:0]  cells;
	} pieceRecord;

	// Direction 0 is horizontal and 1 is vertical
	typedef struct packed
	{
		logic                player;
		shipKind             kind;
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
		logic                direction;
		logic [1:0]          orientation;
	} placeRequest;

	// Wishbone classic write-only slave port
	typedef struct packed
	{
		logic        cyc;
		logic        stb;
		placeRequest data;
	} wbMaster;

	typedef struct packed
	{
		logic       ack;
		placeResult data;
	} wbSlave;

endpackage

`default_nettype wire

/* rtl/shapeGenerator.sv */
`default_nettype none

`include "fleet_macros.svh"

module shapeGenerator import fleetPkg::*;
(
	input  placeRequest request,
	output pieceRecord  piece,
	output logic        fits
);

	// Signed step from the anchor, room for -1 and 15+4
	typedef logic signed [`COORD_W+1:0] coordStep;

	coordStep dx [`MAX_CELLS];
	coordStep dy [`MAX_CELLS];
	coordStep px [`MAX_CELLS];
	coordStep py [`MAX_CELLS];
	logic [2:0] lineLength;
	logic [2:0] cellCount;

	always_comb
	begin
		case (request.kind)
			carrier:    lineLength = 3'd5;
			battleship: lineLength = 3'd4;
			cruiser:    lineLength = 3'd2;
			default:    lineLength = 3'd1;
		endcase
	end

	// ********************************************************************
	// Offsets per kind
	// ********************************************************************

	always_comb
	begin
		cellCount = lineLength;
		for (int i = 0; i < `MAX_CELLS; i++)
		begin
			dx[i] = '0;
			dy[i] = '0;
			if (i < lineLength)
			begin
				if (request.direction)
					dy[i] = coordStep'(i);
				else
					dx[i] = coordStep'(i);
			end
		end

		// Seaplane shape is picked by orientation alone, cell 0 is the anchor
		if (request.kind == seaplane)
		begin
			cellCount = 3'd3;
			case (request.orientation)
				2'd0:
				begin
					dx[1] = coordStep'(1);
					dy[1] = coordStep'(1);
					dx[2] = coordStep'(2);
				end
				2'd1:
				begin
					dx[1] = coordStep'(1);
					dy[1] = -coordStep'(1);
					dx[2] = coordStep'(2);
				end
				2'd2:
				begin
					dx[1] = coordStep'(1);
					dy[1] = coordStep'(1);
					dy[2] = coordStep'(2);
				end
				default:
				begin
					dx[1] = -coordStep'(1);
					dy[1] = coordStep'(1);
					dy[2] = coordStep'(2);
				end
			endcase
		end
	end

	// ********************************************************************
	// Cell positions and bounds
	// ********************************************************************

	always_comb
	begin
		fits = 1'b1;
		piece.kind = request.kind;
		piece.count = cellCount;
		for (int i = 0; i < `MAX_CELLS; i++)
		begin
			px[i] = coordStep'({2'b00, request.x}) + dx[i];
			py[i] = coordStep'({2'b00, request.y}) + dy[i];
			if (i < cellCount)
			begin
				if (px[i] < 0 || px[i] >= `BOARD_SIZE || py[i] < 0 || py[i] >= `BOARD_SIZE)
					fits = 1'b0;
				piece.cells[i].x = px[i][`COORD_W-1:0];
				piece.cells[i].y = py[i][`COORD_W-1:0];
			end
			else
			begin
				piece.cells[i] = '0;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/overlapChecker.sv */
`default_nettype none

`include "fleet_macros.svh"

module overlapChecker import fleetPkg::*;
(
	input  pieceRecord candidate,
	input  pieceRecord stored,
	output logic       hit
);

	logic candidateUsed;
	logic storedUsed;

	// Every used candidate cell against every used stored cell
	always_comb
	begin
		hit = 1'b0;
		candidateUsed = 1'b0;
		storedUsed = 1'b0;
		for (int i = 0; i < `MAX_CELLS; i++)
		begin
			candidateUsed = i < candidate.count;
			for (int j = 0; j < `MAX_CELLS; j++)
			begin
				storedUsed = j < stored.count;
				// Zero padding cells would alias square (0,0)
				if (candidateUsed && storedUsed && candidate.cells[i] == stored.cells[j])
					hit = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/fleetMemory.sv */
`default_nettype none

`include "fleet_macros.svh"

module fleetMemory import fleetPkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               readPlayer,
	input  logic [`SLOT_W-1:0] readSlot,
	input  logic               append,
	input  logic               appendPlayer,
	input  pieceRecord         record,
	output pieceRecord         readData,
	output logic [`SLOT_W-1:0] countOne,
	output logic [`SLOT_W-1:0] countTwo
);

	// Bank 0 is player one, bank 1 player two
	pieceRecord bank [2][`FLEET_SLOTS];

	logic [`SLOT_W-1:0] writeSlot;

	// Next free slot of the bank being written
	assign writeSlot = appendPlayer ? countTwo : countOne;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			countOne <= '0;
			countTwo <= '0;
		end
		else if (append)
		begin
			if (appendPlayer)
				countTwo <= countTwo + 1'b1;
			else
				countOne <= countOne + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (append)
			bank[appendPlayer][writeSlot] <= record;
		readData <= bank[readPlayer][readSlot];
	end

	// Controller must turn a full fleet away before the save step
	appendNotFull: assert property (@(posedge clk) disable iff (reset)
		append |-> writeSlot < `FLEET_SLOTS);

endmodule

`default_nettype wire

/* rtl/placementController.sv */
`default_nettype none

`include "fleet_macros.svh"

module placementController import fleetPkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  wbMaster            bus,
	input  pieceRecord         piece,
	input  logic               fits,
	input  pieceRecord         readData,
	input  logic               hit,
	input  logic [`SLOT_W-1:0] countOne,
	input  logic [`SLOT_W-1:0] countTwo,
	output wbSlave             reply,
	output placeRequest        request,
	output logic               readPlayer,
	output logic [`SLOT_W-1:0] readSlot,
	output logic               append,
	output logic               appendPlayer
);

	ctrlState state;
	placeResult result;

	// Slot whose record is on readData during stScan
	logic [`SLOT_W-1:0] scanSlot;
	logic [`SLOT_W-1:0] fillCount;
	logic fleetFull;
	logic lastSlot;
	logic busRequest;

	assign busRequest = bus.cyc && bus.stb;
	assign fillCount = request.player ? countTwo : countOne;
	assign fleetFull = fillCount == `FLEET_SLOTS;
	assign lastSlot = (scanSlot + 1'b1) == fillCount;

	// ********************************************************************
	// Memory and bus side
	// ********************************************************************

	// Slot 0 goes out in stShape and each later slot one cycle ahead of its compare
	assign readPlayer = request.player;
	assign readSlot = (state == stScan) ? scanSlot + 1'b1 : '0;

	assign append = state == stSave;
	assign appendPlayer = request.player;

	assign reply = '{ack: state == stAck, data: result};

	// ********************************************************************
	// State machine
	// ********************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (busRequest)
						state <= stShape;
				end
				stShape:
				begin
					if (!fits || fleetFull)
						state <= stAck;
					else if (fillCount == '0)
						state <= stSave;
					else
						state <= stScan;
				end
				stScan:
				begin
					// Stop at the first hit
					if (hit)
						state <= stAck;
					else if (lastSlot)
						state <= stSave;
				end
				stSave:
					state <= stAck;
				default:
					state <= stIdle;
			endcase
		end
	end

	// Request, scan index and result
	always_ff @(posedge clk)
	begin
		case (state)
			stIdle:
			begin
				if (busRequest)
					request <= bus.data;
			end
			stShape:
			begin
				scanSlot <= '0;
				if (!fits)
					result <= resOutOfBounds;
				else if (fleetFull)
					result <= resFleetFull;
			end
			stScan:
			begin
				if (hit)
					result <= resOverlap;
				else
					scanSlot <= scanSlot + 1'b1;
			end
			stSave:
				result <= resAccepted;
			default:
			begin
			end
		endcase
	end

	// Ack only answers a live cycle and lasts one clock
	ackUnderStrobe: assert property (@(posedge clk) disable iff (reset)
		reply.ack |-> busRequest);

	ackSinglePulse: assert property (@(posedge clk) disable iff (reset)
		reply.ack |=> !reply.ack);

	// Scanned records come from filled slots
	scanFilledSlot: assert property (@(posedge clk) disable iff (reset)
		state == stScan |-> readData.count != '0);

endmodule

`default_nettype wire

/* rtl/fleetValidator.sv */
`default_nettype none

`include "fleet_macros.svh"

module fleetValidator import fleetPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  wbMaster bus,
	output wbSlave  reply
);

	placeRequest request;
	pieceRecord piece;
	pieceRecord readData;
	logic fits;
	logic hit;
	logic readPlayer;
	logic [`SLOT_W-1:0] readSlot;
	logic append;
	logic appendPlayer;
	logic [`SLOT_W-1:0] countOne;
	logic [`SLOT_W-1:0] countTwo;

	// Candidate piece from the held request
	shapeGenerator u_shape
	(
		.request (request),
		.piece   (piece),
		.fits    (fits)
	);

	overlapChecker u_overlap
	(
		.candidate (piece),
		.stored    (readData),
		.hit       (hit)
	);

	fleetMemory u_memory
	(
		.clk          (clk),
		.reset        (reset),
		.readPlayer   (readPlayer),
		.readSlot     (readSlot),
		.append       (append),
		.appendPlayer (appendPlayer),
		.record       (piece),
		.readData     (readData),
		.countOne     (countOne),
		.countTwo     (countTwo)
	);

	placementController u_control
	(
		.clk          (clk),
		.reset        (reset),
		.bus          (bus),
		.piece        (piece),
		.fits         (fits),
		.readData     (readData),
		.hit          (hit),
		.countOne     (countOne),
		.countTwo     (countTwo),
		.reply        (reply),
		.request      (request),
		.readPlayer   (readPlayer),
		.readSlot     (readSlot),
		.append       (append),
		.appendPlayer (appendPlayer)
	);

endmodule

`default_nettype wire

/* bench/fleetValidatorTb.sv */
`default_nettype none

`include "fleet_macros.svh"

module fleetValidatorTb import fleetPkg::*;
();

	localparam int ACK_TIMEOUT = 50;

	logic clk;
	logic reset;
	wbMaster bus;
	wbSlave reply;

	logic [15:0] lfsr;
	int errors;
	int errorsAtStart;
	int testsRun;
	int testsFailed;
	bit timedOut;

	// Reference model state
	bit occupied [2][`BOARD_SIZE][`BOARD_SIZE];
	int fill [2];
	int shapeX [`MAX_CELLS];
	int shapeY [`MAX_CELLS];
	int shapeCount;
	bit shapeFits;

	fleetValidator u_dut
	(
		.clk   (clk),
		.reset (reset),
		.bus   (bus),
		.reply (reply)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// **********************************************************************
	// Random numbers
	// **********************************************************************

	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [15:0] randomBits(input int width);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < width; i++)
		begin
			lfsr = lfsrStep(lfsr);
			value[i] = lfsr[0];
		end
		return value;
	endfunction

	function automatic shipKind randomKind();
		logic [15:0] k;
		k = randomBits(3);
		return shipKind'(k % 5);
	endfunction

	// Either the low edge or somewhere around the high edge
	function automatic logic [3:0] edgeCoord();
		if (randomBits(1) == 16'd1)
			return 4'd6 + 4'(randomBits(3));
		return 4'(randomBits(1));
	endfunction

	function automatic placeRequest makeRequest(input logic player, input shipKind kind,
		input int x, input int y, input logic direction, input logic [1:0] orientation);
		placeRequest req;
		req.player = player;
		req.kind = kind;
		req.x = 4'(x);
		req.y = 4'(y);
		req.direction = direction;
		req.orientation = orientation;
		return req;
	endfunction

	// **********************************************************************
	// Reference model
	// **********************************************************************

	function automatic void buildShape(input placeRequest req);
		int midX [4] = '{1, 1, 1, -1};
		int midY [4] = '{1, -1, 1, 1};
		int tailX [4] = '{2, 2, 0, 0};
		int tailY [4] = '{0, 0, 2, 2};
		int stepX;
		int stepY;
		case (req.kind)
			carrier:    shapeCount = 5;
			battleship: shapeCount = 4;
			seaplane:   shapeCount = 3;
			cruiser:    shapeCount = 2;
			default:    shapeCount = 1;
		endcase
		stepX = req.direction ? 0 : 1;
		stepY = req.direction ? 1 : 0;
		for (int i = 0; i < shapeCount; i++)
		begin
			shapeX[i] = int'(req.x) + i * stepX;
			shapeY[i] = int'(req.y) + i * stepY;
		end
		// Seaplane ignores direction
		if (req.kind == seaplane)
		begin
			shapeX[0] = int'(req.x);
			shapeY[0] = int'(req.y);
			shapeX[1] = int'(req.x) + midX[req.orientation];
			shapeY[1] = int'(req.y) + midY[req.orientation];
			shapeX[2] = int'(req.x) + tailX[req.orientation];
			shapeY[2] = int'(req.y) + tailY[req.orientation];
		end
		shapeFits = 1'b1;
		for (int i = 0; i < shapeCount; i++)
			if (shapeX[i] < 0 || shapeX[i] >= `BOARD_SIZE || shapeY[i] < 0
				|| shapeY[i] >= `BOARD_SIZE)
				shapeFits = 1'b0;
	endfunction

	function automatic placeResult modelResult(input placeRequest req);
		buildShape(req);
		if (!shapeFits)
			return resOutOfBounds;
		if (fill[req.player] >= `FLEET_SLOTS)
			return resFleetFull;
		for (int i = 0; i < shapeCount; i++)
			if (occupied[req.player][shapeX[i]][shapeY[i]])
				return resOverlap;
		return resAccepted;
	endfunction

	function automatic void commitPiece(input placeRequest req);
		buildShape(req);
		for (int i = 0; i < shapeCount; i++)
			occupied[req.player][shapeX[i]][shapeY[i]] = 1'b1;
		fill[req.player]++;
	endfunction

	function automatic void clearModel();
		for (int p = 0; p < 2; p++)
		begin
			fill[p] = 0;
			for (int x = 0; x < `BOARD_SIZE; x++)
				for (int y = 0; y < `BOARD_SIZE; y++)
					occupied[p][x][y] = 1'b0;
		end
	endfunction

	// **********************************************************************
	// Bus tasks and checks
	// **********************************************************************

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
			errors++;
		end
	endtask

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		bus <= '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		clearModel();
	endtask

	task automatic idleCycles(input int count);
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			checkValue("reply.ack", 0, reply.ack);
		end
	endtask

	// One Wishbone write cycle, checked against the model
	task automatic runPlacement(input placeRequest req, output placeResult got);
		placeResult expected;
		int waitCycles;
		got = resAccepted;
		if (timedOut)
			return;
		expected = modelResult(req);
		@(posedge clk);
		bus <= '{cyc: 1'b1, stb: 1'b1, data: req};
		waitCycles = 0;
		@(negedge clk);
		while (!reply.ack && waitCycles < ACK_TIMEOUT)
		begin
			@(negedge clk);
			waitCycles++;
		end
		if (!reply.ack)
		begin
			$display("Timeout: no ack within %0d cycles at %0t", ACK_TIMEOUT, $time);
			timedOut = 1'b1;
			return;
		end
		got = reply.data;
		checkValue("reply.data", expected, got);
		@(posedge clk);
		bus <= '{cyc: 1'b0, stb: 1'b0, data: req};
		if (expected == resAccepted)
			commitPiece(req);
		// A second ack would show up here
		@(negedge clk);
		checkValue("reply.ack", 0, reply.ack);
		checkValue("countOne", fill[0], u_dut.countOne);
		checkValue("countTwo", fill[1], u_dut.countTwo);
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors > errorsAtStart || timedOut)
		begin
			testsFailed++;
			$display("%s: failed with %0d mismatches", name, errors - errorsAtStart);
		end
		else
		begin
			$display("%s: ok", name);
		end
		errorsAtStart = errors;
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		placeResult got;
		lfsr = 16'd65484;
		reset = 1'b1;
		bus = '0;
		errors = 0;
		errorsAtStart = 0;
		testsRun = 0;
		testsFailed = 0;
		timedOut = 1'b0;
		clearModel();

		// Quiet bus after reset, then a first carrier
		applyReset();
		idleCycles(8);
		checkValue("countOne", 0, u_dut.countOne);
		checkValue("countTwo", 0, u_dut.countTwo);
		runPlacement(makeRequest(1'b0, carrier, 2, 3, 1'b0, 2'd0), got);
		checkValue("reply.data", resAccepted, got);
		finishTest("reset and first placement");

		applyReset();
		for (int i = 0; i < 80; i++)
		begin
			if (i % 20 == 0)
				applyReset();
			runPlacement(makeRequest(randomBits(1) == 16'd1, randomKind(), edgeCoord(),
				edgeCoord(), randomBits(1) == 16'd1, 2'(randomBits(2))), got);
		end
		finishTest("edge bounds");

		applyReset();
		runPlacement(makeRequest(1'b0, battleship, 3, 4, 1'b1, 2'd0), got);
		runPlacement(makeRequest(1'b0, carrier, 1, 6, 1'b0, 2'd0), got);
		checkValue("reply.data", resOverlap, got);
		runPlacement(makeRequest(1'b0, seaplane, 2, 3, 1'b0, 2'd0), got);
		checkValue("reply.data", resOverlap, got);
		runPlacement(makeRequest(1'b0, cruiser, 5, 5, 1'b0, 2'd0), got);
		checkValue("reply.data", resAccepted, got);
		finishTest("overlap");

		applyReset();
		runPlacement(makeRequest(1'b0, carrier, 0, 0, 1'b0, 2'd0), got);
		runPlacement(makeRequest(1'b1, carrier, 0, 0, 1'b0, 2'd0), got);
		checkValue("reply.data", resAccepted, got);
		runPlacement(makeRequest(1'b0, submarine, 4, 0, 1'b0, 2'd0), got);
		runPlacement(makeRequest(1'b1, seaplane, 3, 1, 1'b0, 2'd1), got);
		finishTest("independent fleets");

		// Eleven submarines fill player one's store
		applyReset();
		for (int i = 0; i < `FLEET_SLOTS; i++)
			runPlacement(makeRequest(1'b0, submarine, i % 10, i / 10, 1'b0, 2'd0), got);
		runPlacement(makeRequest(1'b0, submarine, 5, 5, 1'b0, 2'd0), got);
		checkValue("reply.data", resFleetFull, got);
		runPlacement(makeRequest(1'b0, carrier, 8, 5, 1'b0, 2'd0), got);
		runPlacement(makeRequest(1'b1, submarine, 5, 5, 1'b0, 2'd0), got);
		finishTest("fleet full");

		for (int i = 0; i < 300; i++)
		begin
			if (i % 50 == 0)
				applyReset();
			runPlacement(makeRequest(randomBits(1) == 16'd1, randomKind(), 4'(randomBits(4)),
				4'(randomBits(4)), randomBits(1) == 16'd1, 2'(randomBits(2))), got);
			idleCycles(int'(randomBits(2)));
		end
		finishTest("random sequence");

		$display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errors);
		if (errors == 0 && testsFailed == 0 && !timedOut)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/fleetPkg.sv
rtl/shapeGenerator.sv
rtl/overlapChecker.sv
rtl/fleetMemory.sv
rtl/placementController.sv
rtl/fleetValidator.sv
bench/fleetValidatorTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module fleetValidatorTb -o fleetSim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/fleetSim > "$LOG" 2>&1 ; cat "$LOG"
grep -qF "*** TEST PASSED ***" "$LOG" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
